// ==== hyctl_pkg.sv ====
package hyctl_pkg;

    // basic widths
    localparam int BYTE_W     = 8;
    localparam int IP_W       = 32;
    localparam int UDP_PORT_W = 16;
    // 128-byte packet buffer
    localparam int BUF_ADDR_W = 7;

    // port address map, multi-byte groups are given by their base address
    localparam logic [BYTE_W-1:0] PORT_STREAM_LINK = 8'h00;
    localparam logic [BYTE_W-1:0] PORT_PKT_CTRL    = 8'h01;
    localparam logic [BYTE_W-1:0] PORT_IP_CTRL     = 8'h02;
    localparam logic [BYTE_W-1:0] PORT_TX_LEN      = 8'h03;
    // 0x04 high byte, 0x05 low byte
    localparam logic [BYTE_W-1:0] PORT_PKT_PORT    = 8'h04;
    // 0x10-0x13, any write copies the captured packet ip
    localparam logic [BYTE_W-1:0] PORT_STREAM_IP   = 8'h10;
    // 0x14 high byte, 0x15 low byte
    localparam logic [BYTE_W-1:0] PORT_STREAM_UDP  = 8'h14;
    // 0x30-0x33, most significant byte at 0x30
    localparam logic [BYTE_W-1:0] PORT_MY_IP       = 8'h30;
    // buffer window 0x80-0xff
    localparam logic [BYTE_W-1:0] PORT_BUF_BASE    = 8'h80;

    // packet control byte
    localparam int PKT_CTRL_ARM_BIT   = 0;
    localparam int PKT_CTRL_TX_BIT    = 4;
    // ip control byte
    localparam int IP_CTRL_STATIC_BIT = 0;
    localparam int IP_CTRL_VALID_BIT  = 1;

    // tx result code from the udp core
    localparam logic [1:0] UDP_RESULT_ACCEPTED = 2'b01;

    // port-mapped processor bus
    typedef struct packed {
        logic [BYTE_W-1:0] port_id;
        logic [BYTE_W-1:0] out_port;
        logic              write_strobe;
        logic              read_strobe;
    } io_bus_t;

    // receive stream from the udp core
    typedef struct packed {
        logic                  start;
        logic [BYTE_W-1:0]     data;
        logic                  valid;
        logic                  last;
        logic [IP_W-1:0]       src_ip;
        logic [UDP_PORT_W-1:0] src_port;
    } udp_rx_t;

    // transmit stream to the udp core
    typedef struct packed {
        logic                  start;
        logic [BYTE_W-1:0]     data;
        logic                  valid;
        logic                  last;
        logic [BUF_ADDR_W-1:0] length;
        logic [IP_W-1:0]       dst_ip;
        logic [UDP_PORT_W-1:0] dst_port;
    } udp_tx_t;

    // decoded bus writes aimed at the packet engine
    typedef struct packed {
        logic                  pkt_ctrl_wr;
        logic                  tx_len_wr;
        logic                  pkt_port_wr_hi;
        logic                  pkt_port_wr_lo;
        logic                  buf_wr;
        logic [BUF_ADDR_W-1:0] buf_addr;
        logic [BYTE_W-1:0]     data;
    } pkt_wr_t;

    // engine state seen by the port block
    typedef struct packed {
        logic                  arm;
        logic                  receiving;
        logic                  transmitting;
        logic [BUF_ADDR_W-1:0] tx_len;
        logic [IP_W-1:0]       pkt_ip;
    } pkt_status_t;

    typedef struct packed {
        logic            dhcp_reset;
        logic [IP_W-1:0] static_ip;
        logic            static_ip_valid;
    } ip_cfg_t;

    typedef struct packed {
        logic                  linked;
        logic [IP_W-1:0]       ip;
        logic [UDP_PORT_W-1:0] udp_port;
    } stream_cfg_t;

endpackage

// ==== hyctl_packet_buffer.sv ====
`timescale 1ns/100ps

module hyctl_packet_buffer (
    input  logic                              clk,
    input  logic [hyctl_pkg::BUF_ADDR_W-1:0]  addr_i,
    input  logic [hyctl_pkg::BYTE_W-1:0]      wdata_i,
    input  logic                              we_i,
    output logic [hyctl_pkg::BYTE_W-1:0]      rdata_o
);

    localparam int DEPTH = 2 ** hyctl_pkg::BUF_ADDR_W;

    // single port, maps onto block or distributed ram
    logic [hyctl_pkg::BYTE_W-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[addr_i] <= wdata_i;
        end
    end

    // read every cycle, old data on a same-address write
    always_ff @(posedge clk) begin
        rdata_o <= mem[addr_i];
    end

endmodule

// ==== hyctl_packet_engine.sv ====
`timescale 1ns/100ps

module hyctl_packet_engine (
    input  logic                          clk,
    input  logic                          reset,
    input  hyctl_pkg::pkt_wr_t            pkt_wr_i,
    input  hyctl_pkg::udp_rx_t            udp_rx_i,
    input  logic                          udp_tx_ready_i,
    input  logic [1:0]                    udp_tx_result_i,
    output hyctl_pkg::pkt_status_t        pkt_status_o,
    output logic [hyctl_pkg::BYTE_W-1:0]  buf_rdata_o,
    output hyctl_pkg::udp_tx_t            udp_tx_o
);

    // control flags
    logic                             arm_q;
    logic                             receiving_q;
    logic                             transmitting_q;
    logic                             tx_start_q;
    logic                             tx_valid_q;
    logic                             rx_start_q;
    // packet state
    logic [hyctl_pkg::BUF_ADDR_W-1:0] addr_q;
    logic [hyctl_pkg::BUF_ADDR_W-1:0] tx_len_q;
    logic [hyctl_pkg::IP_W-1:0]       pkt_ip_q;
    logic [hyctl_pkg::UDP_PORT_W-1:0] pkt_port_q;
    // decode
    logic                             rx_start_edge;
    logic                             capture_go;
    logic                             rx_active;
    logic                             rx_byte;
    logic                             rx_done;
    logic                             tx_fire;
    logic                             tx_last;
    logic                             tx_go;
    // buffer port
    logic [hyctl_pkg::BUF_ADDR_W-1:0] buf_addr;
    logic [hyctl_pkg::BYTE_W-1:0]     buf_wdata;
    logic                             buf_we;
    logic [hyctl_pkg::BYTE_W-1:0]     buf_rdata;

    // capture starts on a rising start edge, only when armed and idle on tx
    assign rx_start_edge = udp_rx_i.start && !rx_start_q;
    assign capture_go    = arm_q && rx_start_edge && !transmitting_q;
    // first byte can come in the start cycle
    assign rx_active     = receiving_q || capture_go;
    assign rx_byte       = rx_active && udp_rx_i.valid;
    assign rx_done       = rx_byte && udp_rx_i.last;

    assign tx_go   = pkt_wr_i.pkt_ctrl_wr && pkt_wr_i.data[hyctl_pkg::PKT_CTRL_TX_BIT];
    assign tx_fire = transmitting_q && tx_valid_q && udp_tx_ready_i;
    assign tx_last = transmitting_q && (addr_q == tx_len_q);

    always_ff @(posedge clk) begin
        if (reset) begin
            rx_start_q     <= 1'b0;
            arm_q          <= 1'b0;
            receiving_q    <= 1'b0;
            transmitting_q <= 1'b0;
            tx_start_q     <= 1'b0;
            tx_valid_q     <= 1'b0;
            addr_q         <= '0;
        end else begin
            rx_start_q <= udp_rx_i.start;

            // a new arm request beats the clear from a capture
            if (pkt_wr_i.pkt_ctrl_wr && pkt_wr_i.data[hyctl_pkg::PKT_CTRL_ARM_BIT]) begin
                arm_q <= 1'b1;
            end else if (capture_go) begin
                arm_q <= 1'b0;
            end

            // a one-byte packet never enters the receiving state
            if (capture_go && !rx_done) begin
                receiving_q <= 1'b1;
            end else if (receiving_q && rx_done) begin
                receiving_q <= 1'b0;
            end

            if (tx_go) begin
                transmitting_q <= 1'b1;
            end else if (tx_fire && tx_last) begin
                transmitting_q <= 1'b0;
            end

            // start held until the udp core accepts the request
            if (tx_go) begin
                tx_start_q <= 1'b1;
            end else if (tx_start_q && (udp_tx_result_i == hyctl_pkg::UDP_RESULT_ACCEPTED)) begin
                tx_start_q <= 1'b0;
            end

            // valid rises once the buffer has read the current address,
            // and drops for a cycle after each accepted byte
            if (!transmitting_q) begin
                tx_valid_q <= 1'b0;
            end else if (!tx_valid_q) begin
                tx_valid_q <= 1'b1;
            end else if (udp_tx_ready_i) begin
                tx_valid_q <= 1'b0;
            end

            // shared byte counter, parked at zero when idle
            if (!rx_active && !transmitting_q) begin
                addr_q <= '0;
            end else if (rx_byte || tx_fire) begin
                addr_q <= addr_q + 1'b1;
            end
        end
    end

    // length and addressing
    always_ff @(posedge clk) begin
        // final address received is bytes minus one
        if (rx_done) begin
            tx_len_q <= addr_q;
        end else if (pkt_wr_i.tx_len_wr) begin
            tx_len_q <= pkt_wr_i.data[hyctl_pkg::BUF_ADDR_W-1:0];
        end
        if (capture_go) begin
            pkt_ip_q <= udp_rx_i.src_ip;
        end
        if (capture_go) begin
            pkt_port_q <= udp_rx_i.src_port;
        end else if (pkt_wr_i.pkt_port_wr_hi) begin
            pkt_port_q[15:8] <= pkt_wr_i.data;
        end else if (pkt_wr_i.pkt_port_wr_lo) begin
            pkt_port_q[7:0] <= pkt_wr_i.data;
        end
    end

    // buffer ownership: receive, then transmit, then the bus
    assign buf_addr  = (rx_active || transmitting_q) ? addr_q : pkt_wr_i.buf_addr;
    assign buf_wdata = rx_active ? udp_rx_i.data : pkt_wr_i.data;
    assign buf_we    = rx_active ? udp_rx_i.valid : (!transmitting_q && pkt_wr_i.buf_wr);

    hyctl_packet_buffer hyctl_packet_buffer_i (
        .clk     (clk),
        .addr_i  (buf_addr),
        .wdata_i (buf_wdata),
        .we_i    (buf_we),
        .rdata_o (buf_rdata)
    );

    assign buf_rdata_o = buf_rdata;

    assign pkt_status_o.arm          = arm_q;
    assign pkt_status_o.receiving    = receiving_q;
    assign pkt_status_o.transmitting = transmitting_q;
    assign pkt_status_o.tx_len       = tx_len_q;
    assign pkt_status_o.pkt_ip       = pkt_ip_q;

    assign udp_tx_o.start    = tx_start_q;
    assign udp_tx_o.data     = buf_rdata;
    assign udp_tx_o.valid    = tx_valid_q;
    assign udp_tx_o.last     = tx_last;
    assign udp_tx_o.length   = tx_len_q + 1'b1;
    assign udp_tx_o.dst_ip   = pkt_ip_q;
    assign udp_tx_o.dst_port = pkt_port_q;

endmodule

// ==== hyctl_io_ports.sv ====
`timescale 1ns/100ps

module hyctl_io_ports (
    input  logic                              clk,
    input  logic                              reset,
    input  hyctl_pkg::io_bus_t                io_bus_i,
    input  logic [hyctl_pkg::IP_W-1:0]        ext_ip_i,
    input  logic                              ext_ip_force_i,
    input  hyctl_pkg::pkt_status_t            pkt_status_i,
    input  logic [hyctl_pkg::BYTE_W-1:0]      buf_rdata_i,
    output hyctl_pkg::pkt_wr_t                pkt_wr_o,
    output logic [hyctl_pkg::BYTE_W-1:0]      in_port_o,
    output hyctl_pkg::ip_cfg_t                ip_cfg_o,
    output hyctl_pkg::stream_cfg_t            stream_cfg_o
);

    // receiving flag position in the packet status byte
    localparam int STAT_RX_BIT = 1;

    logic [hyctl_pkg::BYTE_W-1:0]     port_id;
    logic [hyctl_pkg::BYTE_W-1:0]     wdata;
    logic                             wr_en;
    // big endian byte lane, 0x30 selects bits 31:24
    logic [1:0]                       byte_sel;
    logic                             hit_my_ip;
    logic                             hit_stream_ip;
    logic                             hit_stream_udp;
    logic                             hit_pkt_port;
    // configuration state
    logic                             linked_q;
    logic                             use_static_q;
    logic                             static_valid_q;
    logic [hyctl_pkg::IP_W-1:0]       my_ip_q;
    logic [hyctl_pkg::IP_W-1:0]       stream_ip_q;
    logic [hyctl_pkg::UDP_PORT_W-1:0] stream_udp_q;
    // ip read-back
    logic                             use_ext_ip;
    logic [hyctl_pkg::IP_W-1:0]       ip_src;
    logic [hyctl_pkg::BYTE_W-1:0]     ip_byte_q;
    logic [hyctl_pkg::BYTE_W-1:0]     status_byte;

    assign port_id  = io_bus_i.port_id;
    assign wdata    = io_bus_i.out_port;
    // a cycle with both strobes is not a valid bus write
    assign wr_en    = io_bus_i.write_strobe && !io_bus_i.read_strobe;
    assign byte_sel = 2'd3 - port_id[1:0];

    assign hit_my_ip      = port_id[7:2] == hyctl_pkg::PORT_MY_IP[7:2];
    assign hit_stream_ip  = port_id[7:2] == hyctl_pkg::PORT_STREAM_IP[7:2];
    assign hit_stream_udp = port_id[7:1] == hyctl_pkg::PORT_STREAM_UDP[7:1];
    assign hit_pkt_port   = port_id[7:1] == hyctl_pkg::PORT_PKT_PORT[7:1];

    // engine writes, the buffer address also serves bus reads
    assign pkt_wr_o.pkt_ctrl_wr    = wr_en && (port_id == hyctl_pkg::PORT_PKT_CTRL);
    assign pkt_wr_o.tx_len_wr      = wr_en && (port_id == hyctl_pkg::PORT_TX_LEN);
    assign pkt_wr_o.pkt_port_wr_hi = wr_en && hit_pkt_port && !port_id[0];
    assign pkt_wr_o.pkt_port_wr_lo = wr_en && hit_pkt_port && port_id[0];
    assign pkt_wr_o.buf_wr         = wr_en && port_id[7];
    assign pkt_wr_o.buf_addr       = port_id[hyctl_pkg::BUF_ADDR_W-1:0];
    assign pkt_wr_o.data           = wdata;

    // control bits
    always_ff @(posedge clk) begin
        if (reset) begin
            linked_q       <= 1'b0;
            use_static_q   <= 1'b0;
            static_valid_q <= 1'b0;
        end else if (wr_en) begin
            if (port_id == hyctl_pkg::PORT_STREAM_LINK) begin
                linked_q <= wdata[0];
            end
            if (port_id == hyctl_pkg::PORT_IP_CTRL) begin
                use_static_q   <= wdata[hyctl_pkg::IP_CTRL_STATIC_BIT];
                static_valid_q <= wdata[hyctl_pkg::IP_CTRL_VALID_BIT];
            end
        end
    end

    // address and port payload
    always_ff @(posedge clk) begin
        if (wr_en && hit_my_ip) begin
            my_ip_q[byte_sel*hyctl_pkg::BYTE_W +: hyctl_pkg::BYTE_W] <= wdata;
        end
        // stream ip is not written bytewise, it takes the last packet source
        if (wr_en && hit_stream_ip) begin
            stream_ip_q <= pkt_status_i.pkt_ip;
        end
        if (wr_en && hit_stream_udp) begin
            if (port_id[0]) begin
                stream_udp_q[7:0] <= wdata;
            end else begin
                stream_udp_q[15:8] <= wdata;
            end
        end
    end

    // external ip wins unless static is selected and not forced off
    assign use_ext_ip = !use_static_q || ext_ip_force_i;
    assign ip_src     = use_ext_ip ? ext_ip_i : my_ip_q;

    // registered like the buffer so both reads take the same two cycles
    always_ff @(posedge clk) begin
        ip_byte_q <= ip_src[byte_sel*hyctl_pkg::BYTE_W +: hyctl_pkg::BYTE_W];
    end

    always_comb begin
        status_byte = '0;
        status_byte[hyctl_pkg::PKT_CTRL_TX_BIT]  = pkt_status_i.transmitting;
        status_byte[STAT_RX_BIT]                 = pkt_status_i.receiving;
        status_byte[hyctl_pkg::PKT_CTRL_ARM_BIT] = pkt_status_i.arm;
    end

    // read data, everything unmapped reads zero
    always_comb begin
        in_port_o = '0;
        if (port_id[7]) begin
            in_port_o = buf_rdata_i;
        end else if (hit_my_ip) begin
            in_port_o = ip_byte_q;
        end else if (port_id == hyctl_pkg::PORT_TX_LEN) begin
            in_port_o = {1'b0, pkt_status_i.tx_len};
        end else if (port_id == hyctl_pkg::PORT_PKT_CTRL) begin
            in_port_o = status_byte;
        end
    end

    // dhcp is held in reset while a static ip is in use
    assign ip_cfg_o.dhcp_reset      = use_static_q;
    assign ip_cfg_o.static_ip       = my_ip_q;
    assign ip_cfg_o.static_ip_valid = static_valid_q;

    assign stream_cfg_o.linked   = linked_q;
    assign stream_cfg_o.ip       = stream_ip_q;
    assign stream_cfg_o.udp_port = stream_udp_q;

endmodule

// ==== hyctl_top.sv ====
`timescale 1ns/100ps

module hyctl_top (
    input  logic                          clk,
    input  logic                          reset,
    // processor port bus
    input  hyctl_pkg::io_bus_t            io_bus_i,
    output logic [hyctl_pkg::BYTE_W-1:0]  in_port_o,
    // udp core
    input  hyctl_pkg::udp_rx_t            udp_rx_i,
    input  logic                          udp_tx_ready_i,
    input  logic [1:0]                    udp_tx_result_i,
    output hyctl_pkg::udp_tx_t            udp_tx_o,
    // ip address source, force overrides any static setting
    input  logic [hyctl_pkg::IP_W-1:0]    ext_ip_i,
    input  logic                          ext_ip_force_i,
    // configuration out
    output hyctl_pkg::ip_cfg_t            ip_cfg_o,
    output hyctl_pkg::stream_cfg_t        stream_cfg_o
);

    // port block to engine
    hyctl_pkg::pkt_wr_t           pkt_wr;
    // engine back to port block
    hyctl_pkg::pkt_status_t       pkt_status;
    logic [hyctl_pkg::BYTE_W-1:0] buf_rdata;

    // register file and read mux
    hyctl_io_ports hyctl_io_ports_i (
        .clk            (clk),
        .reset          (reset),
        .io_bus_i       (io_bus_i),
        .ext_ip_i       (ext_ip_i),
        .ext_ip_force_i (ext_ip_force_i),
        .pkt_status_i   (pkt_status),
        .buf_rdata_i    (buf_rdata),
        .pkt_wr_o       (pkt_wr),
        .in_port_o      (in_port_o),
        .ip_cfg_o       (ip_cfg_o),
        .stream_cfg_o   (stream_cfg_o)
    );

    // rx capture, tx streaming and the packet buffer
    hyctl_packet_engine hyctl_packet_engine_i (
        .clk             (clk),
        .reset           (reset),
        .pkt_wr_i        (pkt_wr),
        .udp_rx_i        (udp_rx_i),
        .udp_tx_ready_i  (udp_tx_ready_i),
        .udp_tx_result_i (udp_tx_result_i),
        .pkt_status_o    (pkt_status),
        .buf_rdata_o     (buf_rdata),
        .udp_tx_o        (udp_tx_o)
    );

endmodule

// ==== tb_hyctl_assertions.sv ====
`timescale 1ns/100ps

module tb_hyctl_assertions (
    input logic                   clk,
    input logic                   reset,
    input hyctl_pkg::udp_tx_t     udp_tx_i,
    input logic                   udp_tx_ready_i,
    input logic [1:0]             udp_tx_result_i,
    input hyctl_pkg::pkt_status_t pkt_status_i
);

    logic tx_fire;
    logic accepted;

    assign tx_fire  = udp_tx_i.valid && udp_tx_ready_i;
    assign accepted = udp_tx_result_i == hyctl_pkg::UDP_RESULT_ACCEPTED;

    // start stays up until the udp core accepts
    property start_held_p;
        @(posedge clk) disable iff (reset)
        udp_tx_i.start && !accepted |=> udp_tx_i.start;
    endproperty
    start_held_a: assert property (start_held_p)
        else $error("udp_tx start dropped before the accepted result");

    // back-pressure holds the offered byte
    property backpressure_p;
        @(posedge clk) disable iff (reset)
        udp_tx_i.valid && !udp_tx_ready_i |=> udp_tx_i.valid && $stable(udp_tx_i.data);
    endproperty
    backpressure_a: assert property (backpressure_p)
        else $error("udp_tx valid or data changed while ready was low");

    // one idle cycle after each accepted byte while the next is read
    property gap_after_fire_p;
        @(posedge clk) disable iff (reset)
        tx_fire |=> !udp_tx_i.valid;
    endproperty
    gap_after_fire_a: assert property (gap_after_fire_p)
        else $error("udp_tx valid stayed high after an accepted byte");

    property last_in_tx_p;
        @(posedge clk) disable iff (reset)
        udp_tx_i.last |-> pkt_status_i.transmitting;
    endproperty
    last_in_tx_a: assert property (last_in_tx_p)
        else $error("udp_tx last seen outside a transmit");

    // accepted last byte closes the transmit
    property last_ends_tx_p;
        @(posedge clk) disable iff (reset)
        tx_fire && udp_tx_i.last |=> !pkt_status_i.transmitting;
    endproperty
    last_ends_tx_a: assert property (last_ends_tx_p)
        else $error("transmit still active after the last byte");

    property reset_idle_p;
        @(posedge clk)
        reset |=> !udp_tx_i.valid && !udp_tx_i.start;
    endproperty
    reset_idle_a: assert property (reset_idle_p)
        else $error("udp_tx valid or start high after reset");

endmodule

// ==== tb_hyctl.sv ====
`timescale 1ns/100ps

module tb_hyctl;

    localparam int CLK_PERIOD   = 10;
    localparam int DRIVE_DLY    = 1;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_PKTS     = 4;
    localparam int MAX_LEN      = 32;
    // worst case cycles per packet byte over receive, read-back and echo
    localparam int CYCLE_BUDGET = 24;
    localparam int SETUP_CYCLES = 300;
    localparam int TIMEOUT_CYCLES = NUM_PKTS * MAX_LEN * CYCLE_BUDGET + SETUP_CYCLES;
    localparam logic [31:0] LFSR_SEED     = 32'hc406_7520;
    localparam logic [31:0] MY_IP         = 32'hc0a8_0a21;
    localparam logic [31:0] EXT_IP        = 32'h0a00_0107;
    localparam logic [15:0] STREAM_UDP    = 16'h1f90;
    localparam logic [15:0] OVERRIDE_PORT = 16'h2329;

    logic                   clk;
    logic                   reset;
    hyctl_pkg::io_bus_t     io_bus;
    logic [7:0]             in_port;
    hyctl_pkg::udp_rx_t     udp_rx;
    logic                   udp_tx_ready;
    logic [1:0]             udp_tx_result;
    logic [31:0]            ext_ip;
    logic                   ext_ip_force;
    hyctl_pkg::udp_tx_t     udp_tx;
    hyctl_pkg::ip_cfg_t     ip_cfg;
    hyctl_pkg::stream_cfg_t stream_cfg;

    logic [31:0] lfsr_state;
    // bytes sent on the rx stream and the expected buffer contents
    logic [7:0]  pkt_bytes [128];
    logic [7:0]  buf_model [128];

    hyctl_top hyctl_top_i (
        .clk             (clk),
        .reset           (reset),
        .io_bus_i        (io_bus),
        .in_port_o       (in_port),
        .udp_rx_i        (udp_rx),
        .udp_tx_ready_i  (udp_tx_ready),
        .udp_tx_result_i (udp_tx_result),
        .udp_tx_o        (udp_tx),
        .ext_ip_i        (ext_ip),
        .ext_ip_force_i  (ext_ip_force),
        .ip_cfg_o        (ip_cfg),
        .stream_cfg_o    (stream_cfg)
    );

    bind hyctl_top tb_hyctl_assertions tb_hyctl_assertions_i (
        .clk             (clk),
        .reset           (reset),
        .udp_tx_i        (udp_tx_o),
        .udp_tx_ready_i  (udp_tx_ready_i),
        .udp_tx_result_i (udp_tx_result_i),
        .pkt_status_i    (pkt_status)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // fibonacci lfsr with taps 32 22 2 1
    // stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        logic        fb;
        int          i;
        value = '0;
        for (i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp);
            $display("Testbench failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    // strobe high for one cycle and the register updates on that edge
    task automatic bus_write(input logic [7:0] port, input logic [7:0] data);
        @(posedge clk);
        #DRIVE_DLY;
        io_bus.port_id      = port;
        io_bus.out_port     = data;
        io_bus.write_strobe = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        io_bus.write_strobe = 1'b0;
    endtask

    // port held two cycles with data valid in the second
    task automatic bus_read(input logic [7:0] port, output logic [7:0] data);
        @(posedge clk);
        #DRIVE_DLY;
        io_bus.port_id     = port;
        io_bus.read_strobe = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        io_bus.read_strobe = 1'b0;
        @(negedge clk);
        data = in_port;
    endtask

    task automatic check_ip_readback(input logic [31:0] exp);
        logic [7:0] b;
        int         i;
        for (i = 0; i < 4; i++) begin
            bus_read(hyctl_pkg::PORT_MY_IP + 8'(i), b);
            check_hex("in_port_o ip byte", 32'(b), 32'(exp[(3 - i) * 8 +: 8]));
        end
    endtask

    task automatic check_buffer(input int len);
        logic [7:0] b;
        int         i;
        for (i = 0; i < len; i++) begin
            bus_read(hyctl_pkg::PORT_BUF_BASE + 8'(i), b);
            check_hex("in_port_o buffer byte", 32'(b), 32'(buf_model[i]));
        end
    endtask

    task automatic fill_packet(input int len);
        int i;
        for (i = 0; i < len; i++) begin
            pkt_bytes[i] = 8'(rand_bits(8));
        end
    endtask

    // first byte rides with start and later bytes have random gaps
    task automatic receive_packet(input int len, input logic [31:0] ip, input logic [15:0] port);
        int idx;
        idx = 0;
        @(posedge clk);
        #DRIVE_DLY;
        udp_rx.start    = 1'b1;
        udp_rx.src_ip   = ip;
        udp_rx.src_port = port;
        while (idx < len) begin
            if (idx == 0 || rand_bits(2) != 0) begin
                udp_rx.valid = 1'b1;
                udp_rx.data  = pkt_bytes[idx];
                udp_rx.last  = (idx == len - 1);
                idx++;
            end else begin
                udp_rx.valid = 1'b0;
                udp_rx.last  = 1'b0;
            end
            @(posedge clk);
            #DRIVE_DLY;
            udp_rx.start = 1'b0;
        end
        udp_rx.valid = 1'b0;
        udp_rx.last  = 1'b0;
        @(posedge clk);
    endtask

    // random ready and a random wait before the accepted result
    task automatic transmit_echo(input int len, input logic [31:0] ip, input logic [15:0] port);
        int   idx;
        int   wait_cnt;
        int   accept_at;
        logic done;
        idx       = 0;
        wait_cnt  = 0;
        done      = 1'b0;
        accept_at = int'(rand_bits(2));
        bus_write(hyctl_pkg::PORT_PKT_CTRL, 8'h10);
        while (!done || udp_tx.start) begin
            udp_tx_ready  = !done && (rand_bits(2) != 0);
            udp_tx_result = (udp_tx.start && wait_cnt == accept_at) ?
                            hyctl_pkg::UDP_RESULT_ACCEPTED : 2'b00;
            if (udp_tx.start) begin
                wait_cnt++;
            end
            @(negedge clk);
            if (udp_tx.valid && udp_tx_ready) begin
                check_hex("udp_tx_o.data", 32'(udp_tx.data), 32'(buf_model[idx]));
                check_hex("udp_tx_o.last", 32'(udp_tx.last), 32'(idx == len - 1));
                check_hex("udp_tx_o.length", 32'(udp_tx.length), 32'(len));
                check_hex("udp_tx_o.dst_ip", udp_tx.dst_ip, ip);
                check_hex("udp_tx_o.dst_port", 32'(udp_tx.dst_port), 32'(port));
                done = udp_tx.last;
                idx++;
            end
            @(posedge clk);
            #DRIVE_DLY;
        end
        udp_tx_ready  = 1'b0;
        udp_tx_result = 2'b00;
    endtask

    // watchdog sized from packet count and length
    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Testbench failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic [7:0]  b;
        logic [31:0] src_ip;
        logic [15:0] src_port;
        logic [15:0] dst_port;
        int          len;
        int          p;
        int          i;
        lfsr_state    = LFSR_SEED;
        reset         = 1'b1;
        io_bus        = '0;
        udp_rx        = '0;
        udp_tx_ready  = 1'b0;
        udp_tx_result = 2'b00;
        ext_ip        = EXT_IP;
        ext_ip_force  = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        reset = 1'b0;
        @(negedge clk);
        check_hex("udp_tx_o.start", 32'(udp_tx.start), 32'h0);
        check_hex("udp_tx_o.valid", 32'(udp_tx.valid), 32'h0);
        check_hex("udp_tx_o.last", 32'(udp_tx.last), 32'h0);
        check_hex("ip_cfg_o.dhcp_reset", 32'(ip_cfg.dhcp_reset), 32'h0);
        check_hex("ip_cfg_o.static_ip_valid", 32'(ip_cfg.static_ip_valid), 32'h0);
        check_hex("stream_cfg_o.linked", 32'(stream_cfg.linked), 32'h0);

        // configuration registers
        for (i = 0; i < 4; i++) begin
            bus_write(hyctl_pkg::PORT_MY_IP + 8'(i), MY_IP[(3 - i) * 8 +: 8]);
        end
        bus_write(hyctl_pkg::PORT_IP_CTRL, 8'h03);
        bus_write(hyctl_pkg::PORT_STREAM_UDP, STREAM_UDP[15:8]);
        bus_write(hyctl_pkg::PORT_STREAM_UDP + 8'd1, STREAM_UDP[7:0]);
        bus_write(hyctl_pkg::PORT_STREAM_LINK, 8'h01);
        check_hex("ip_cfg_o.static_ip", ip_cfg.static_ip, MY_IP);
        check_hex("ip_cfg_o.dhcp_reset", 32'(ip_cfg.dhcp_reset), 32'h1);
        check_hex("ip_cfg_o.static_ip_valid", 32'(ip_cfg.static_ip_valid), 32'h1);
        check_hex("stream_cfg_o.udp_port", 32'(stream_cfg.udp_port), 32'(STREAM_UDP));
        check_hex("stream_cfg_o.linked", 32'(stream_cfg.linked), 32'h1);

        // ip read-back as static then forced external then plain external
        check_ip_readback(MY_IP);
        @(posedge clk);
        #DRIVE_DLY;
        ext_ip_force = 1'b1;
        check_ip_readback(EXT_IP);
        @(posedge clk);
        #DRIVE_DLY;
        ext_ip_force = 1'b0;
        bus_write(hyctl_pkg::PORT_IP_CTRL, 8'h02);
        check_hex("ip_cfg_o.dhcp_reset", 32'(ip_cfg.dhcp_reset), 32'h0);
        check_ip_readback(EXT_IP);

        for (p = 0; p < NUM_PKTS; p++) begin
            len = (p == 2) ? 1 : 1 + int'(rand_bits(5));
            src_ip   = rand_bits(32);
            src_port = 16'(rand_bits(16));
            fill_packet(len);
            bus_write(hyctl_pkg::PORT_PKT_CTRL, 8'h01);
            bus_read(hyctl_pkg::PORT_PKT_CTRL, b);
            check_hex("in_port_o pkt status", 32'(b), 32'h01);
            receive_packet(len, src_ip, src_port);
            for (i = 0; i < len; i++) begin
                buf_model[i] = pkt_bytes[i];
            end
            // arm is consumed by the capture
            bus_read(hyctl_pkg::PORT_PKT_CTRL, b);
            check_hex("in_port_o pkt status", 32'(b), 32'h00);
            bus_read(hyctl_pkg::PORT_TX_LEN, b);
            check_hex("in_port_o tx_len", 32'(b), 32'(len - 1));
            check_buffer(len);
            bus_write(hyctl_pkg::PORT_STREAM_IP, 8'h00);
            check_hex("stream_cfg_o.ip", stream_cfg.ip, src_ip);
            dst_port = src_port;
            if (p == NUM_PKTS - 1) begin
                bus_write(hyctl_pkg::PORT_PKT_PORT, OVERRIDE_PORT[15:8]);
                bus_write(hyctl_pkg::PORT_PKT_PORT + 8'd1, OVERRIDE_PORT[7:0]);
                dst_port = OVERRIDE_PORT;
            end
            transmit_echo(len, src_ip, dst_port);
            if (p == 1) begin
                // unarmed packet must not touch buffer or length
                fill_packet(MAX_LEN);
                receive_packet(MAX_LEN, ~src_ip, ~src_port);
                check_buffer(len);
                bus_read(hyctl_pkg::PORT_TX_LEN, b);
                check_hex("in_port_o tx_len", 32'(b), 32'(len - 1));
            end
        end

        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== hyctl.f ====
hyctl_pkg.sv
hyctl_packet_buffer.sv
hyctl_packet_engine.sv
hyctl_io_ports.sv
hyctl_top.sv
tb_hyctl_assertions.sv
tb_hyctl.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the hyctl testbench with verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
        --timescale 1ns/100ps --top-module tb_hyctl \
        -Mdir obj_dir -f hyctl.f > "$BUILD_LOG" 2>&1; then
    cat "$BUILD_LOG"
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_hyctl > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

if grep -q "Testbench failed" "$SIM_LOG"; then
    exit 1
fi
if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi
exit 0
